/* logic/hydra_pkg.sv */
package hydra_pkg;

    // ============================================================
    // switch dimensions.
    // ============================================================
    localparam int num_ports  = 4;
    localparam int port_w     = 2;
    localparam int num_priors = 4;    // 3 is served first.
    localparam int prior_w    = 2;
    localparam int num_slots  = 16;
    localparam int slot_w     = 4;
    localparam int slot_words = 16;   // header included.
    localparam int idx_w      = 4;    // word index inside a slot.
    localparam int word_w     = 16;

    // ============================================================
    // first word of a packet, seen as data or as header fields.
    // ============================================================
    typedef union packed {
        logic [word_w-1:0] data;
        struct packed {
            logic [idx_w-1:0]   length;   // packet words minus one.
            logic [7:0]         rsvd;
            logic [prior_w-1:0] prior;
            logic [port_w-1:0]  dest;
        } hdr;
    } hdr_word_t;

endpackage

/* logic/port_wr_frontend.sv */
`timescale 1ns/1ps

module port_wr_frontend (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wr_sop,
    input  logic                          wr_eop,
    input  logic                          wr_vld,
    input  logic [hydra_pkg::word_w-1:0]  wr_data,
    output logic                          pause,
    output logic                          rsv_req,
    input  logic                          rsv_vld,
    input  logic [hydra_pkg::slot_w-1:0]  rsv_slot,
    output logic                          buf_we,
    output logic [hydra_pkg::slot_w-1:0]  buf_slot,
    output logic [hydra_pkg::idx_w-1:0]   buf_idx,
    output logic [hydra_pkg::word_w-1:0]  buf_data,
    output logic                          join_req,
    output logic [hydra_pkg::port_w-1:0]  join_dest,
    output logic [hydra_pkg::prior_w-1:0] join_prior,
    output logic [hydra_pkg::slot_w-1:0]  join_slot,
    input  logic                          join_grant
);

    hydra_pkg::hdr_word_t hdr_in;
    logic                        have_slot;   // a slot is reserved for the next packet.
    logic [hydra_pkg::slot_w-1:0] slot_q;
    logic [hydra_pkg::idx_w-1:0]  idx_q;
    logic [hydra_pkg::idx_w-1:0]  len_q;
    logic [hydra_pkg::idx_w-1:0]  len_cur;

    assign hdr_in  = wr_data;
    assign len_cur = wr_sop ? hdr_in.hdr.length : len_q;

    // hold the source off until a slot is ready and the last packet has joined.
    assign pause   = ~have_slot | join_req;
    assign rsv_req = ~have_slot;

    // words go straight into the reserved slot.
    assign buf_we   = wr_vld;
    assign buf_slot = slot_q;
    assign buf_idx  = wr_sop ? '0 : idx_q;
    assign buf_data = wr_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            have_slot <= 1'b0;
            join_req  <= 1'b0;
        end else begin
            if (rsv_vld) begin
                have_slot <= 1'b1;
            end else if (wr_vld && wr_eop) begin
                have_slot <= 1'b0;                 // slot now belongs to the join request.
            end
            if (wr_vld && wr_eop) begin
                join_req <= 1'b1;
            end else if (join_grant) begin
                join_req <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsv_vld) slot_q <= rsv_slot;
        if (wr_vld) idx_q <= buf_idx + 1'b1;
        if (wr_vld && wr_sop) begin
            len_q      <= hdr_in.hdr.length;
            join_dest  <= hdr_in.hdr.dest;
            join_prior <= hdr_in.hdr.prior;
        end
        if (wr_vld && wr_eop) join_slot <= slot_q;
    end

    // the source keeps quiet while paused.
    assert property (@(posedge clk) disable iff (!rst_n) wr_vld |-> !pause);

    // eop lands exactly on the word the header announced.
    assert property (@(posedge clk) disable iff (!rst_n)
        wr_vld && wr_eop |-> buf_idx == len_cur);

endmodule

/* logic/slot_allocator.sv */
`timescale 1ns/1ps

module slot_allocator (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic [hydra_pkg::num_ports-1:0]                     rsv_req,
    output logic [hydra_pkg::num_ports-1:0]                     rsv_vld,
    output logic [hydra_pkg::slot_w-1:0]                        rsv_slot,
    input  logic [hydra_pkg::num_ports-1:0]                     free,
    input  logic [hydra_pkg::num_ports-1:0][hydra_pkg::slot_w-1:0] free_slot,
    output logic                                                full
);

    logic [hydra_pkg::num_slots-1:0] free_mask;
    logic [hydra_pkg::num_slots-1:0] taken;
    logic [hydra_pkg::num_slots-1:0] freed;
    logic                            any_free;

    // lowest free slot.
    always_comb begin
        any_free = 1'b0;
        rsv_slot = '0;
        for (int s = hydra_pkg::num_slots - 1; s >= 0; s--) begin
            if (free_mask[s]) begin
                any_free = 1'b1;
                rsv_slot = hydra_pkg::slot_w'(s);
            end
        end
    end

    // lowest requesting port gets it.
    assign rsv_vld = any_free ? (rsv_req & (~rsv_req + 1'b1)) : '0;
    assign taken   = (|rsv_vld) ? (hydra_pkg::num_slots'(1) << rsv_slot) : '0;

    always_comb begin
        freed = '0;
        for (int p = 0; p < hydra_pkg::num_ports; p++) begin
            if (free[p]) freed[free_slot[p]] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            free_mask <= '1;
            full      <= 1'b0;
        end else begin
            free_mask <= (free_mask & ~taken) | freed;
            full      <= free_mask == '0;   // follows the mask by one cycle.
        end
    end

    // an output only returns a slot that the pool handed out.
    for (genvar p = 0; p < hydra_pkg::num_ports; p++) begin : g_chk
        assert property (@(posedge clk) disable iff (!rst_n)
            free[p] |-> !free_mask[free_slot[p]]);
    end

endmodule

/* logic/packet_buffer.sv */
`timescale 1ns/1ps

module packet_buffer (
    input  logic                                                clk,
    input  logic [hydra_pkg::num_ports-1:0]                     we,
    input  logic [hydra_pkg::num_ports-1:0][hydra_pkg::slot_w-1:0] slot,
    input  logic [hydra_pkg::num_ports-1:0][hydra_pkg::idx_w-1:0]  idx,
    input  logic [hydra_pkg::num_ports-1:0][hydra_pkg::word_w-1:0] data,
    input  logic [hydra_pkg::num_ports-1:0][hydra_pkg::slot_w-1:0] rd_slot,
    input  logic [hydra_pkg::num_ports-1:0][hydra_pkg::idx_w-1:0]  rd_idx,
    output logic [hydra_pkg::num_ports-1:0][hydra_pkg::word_w-1:0] rd_data
);

    logic [hydra_pkg::word_w-1:0] mem [hydra_pkg::num_slots][hydra_pkg::slot_words];

    // one owner per slot, so the writes never meet.
    always_ff @(posedge clk) begin
        for (int p = 0; p < hydra_pkg::num_ports; p++) begin
            if (we[p]) mem[slot[p]][idx[p]] <= data[p];
        end
    end

    for (genvar p = 0; p < hydra_pkg::num_ports; p++) begin : g_rd
        assign rd_data[p] = mem[rd_slot[p]][rd_idx[p]];   // combinational read.
    end

endmodule

/* logic/join_arbiter.sv */
`timescale 1ns/1ps

module join_arbiter (
    input  logic [hydra_pkg::num_ports-1:0]                         join_req,
    input  logic [hydra_pkg::num_ports-1:0][hydra_pkg::port_w-1:0]  join_dest,
    input  logic [hydra_pkg::num_ports-1:0][hydra_pkg::prior_w-1:0] join_prior,
    input  logic [hydra_pkg::num_ports-1:0][hydra_pkg::slot_w-1:0]  join_slot,
    output logic [hydra_pkg::num_ports-1:0]                         join_grant,
    output logic [hydra_pkg::num_ports-1:0]                         enq,
    output logic [hydra_pkg::num_ports-1:0][hydra_pkg::prior_w-1:0] enq_prior,
    output logic [hydra_pkg::num_ports-1:0][hydra_pkg::slot_w-1:0]  enq_slot
);

    // per output, the first requesting input in index order wins.
    always_comb begin
        join_grant = '0;
        enq        = '0;
        enq_prior  = '0;
        enq_slot   = '0;
        for (int o = 0; o < hydra_pkg::num_ports; o++) begin
            for (int i = 0; i < hydra_pkg::num_ports; i++) begin
                if (!enq[o] && join_req[i] && join_dest[i] == hydra_pkg::port_w'(o)) begin
                    enq[o]        = 1'b1;
                    enq_prior[o]  = join_prior[i];
                    enq_slot[o]   = join_slot[i];
                    join_grant[i] = 1'b1;
                end
            end
        end
    end

endmodule

/* logic/output_queue.sv */
`timescale 1ns/1ps

module output_queue (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          enq,
    input  logic [hydra_pkg::prior_w-1:0] enq_prior,
    input  logic [hydra_pkg::slot_w-1:0]  enq_slot,
    input  logic                          pop,
    output logic                          nonempty,
    output logic [hydra_pkg::slot_w-1:0]  head_slot
);

    logic [hydra_pkg::slot_w-1:0] fifo [hydra_pkg::num_priors][hydra_pkg::num_slots];

    // extra bit tells a full ring from an empty one.
    logic [hydra_pkg::num_priors-1:0][hydra_pkg::slot_w:0] wr_ptr;
    logic [hydra_pkg::num_priors-1:0][hydra_pkg::slot_w:0] rd_ptr;
    logic [hydra_pkg::num_priors-1:0]                      has_pkt;
    logic [hydra_pkg::prior_w-1:0]                         sel;

    always_comb begin
        for (int q = 0; q < hydra_pkg::num_priors; q++) begin
            has_pkt[q] = wr_ptr[q] != rd_ptr[q];
        end
    end

    // strict priority: the highest busy queue is the last one seen.
    always_comb begin
        sel = '0;
        for (int q = 0; q < hydra_pkg::num_priors; q++) begin
            if (has_pkt[q]) sel = hydra_pkg::prior_w'(q);
        end
    end

    assign nonempty  = |has_pkt;
    assign head_slot = fifo[sel][rd_ptr[sel][hydra_pkg::slot_w-1:0]];

    always_ff @(posedge clk) begin
        if (enq) fifo[enq_prior][wr_ptr[enq_prior][hydra_pkg::slot_w-1:0]] <= enq_slot;
    end

    // ============================================================
    // pointers.
    // ============================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (enq) wr_ptr[enq_prior] <= wr_ptr[enq_prior] + 1'b1;
            if (pop) rd_ptr[sel] <= rd_ptr[sel] + 1'b1;   // head leaves on the pop edge.
        end
    end

    // the read side only pops what it was told is there.
    assert property (@(posedge clk) disable iff (!rst_n) pop |-> nonempty);

endmodule

/* logic/port_rd_frontend.sv */
`timescale 1ns/1ps

module port_rd_frontend (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          ready,
    input  logic                          nonempty,
    input  logic [hydra_pkg::slot_w-1:0]  head_slot,
    output logic                          pop,
    output logic [hydra_pkg::slot_w-1:0]  rd_slot,
    output logic [hydra_pkg::idx_w-1:0]   rd_idx,
    input  logic [hydra_pkg::word_w-1:0]  rd_word,
    output logic                          rd_sop,
    output logic                          rd_eop,
    output logic                          rd_vld,
    output logic [hydra_pkg::word_w-1:0]  rd_data,
    output logic                          free,
    output logic [hydra_pkg::slot_w-1:0]  free_slot
);

    hydra_pkg::hdr_word_t         word_in;
    logic                         busy;
    logic                         last;
    logic [hydra_pkg::slot_w-1:0] slot_q;
    logic [hydra_pkg::idx_w-1:0]  idx_q;
    logic [hydra_pkg::idx_w-1:0]  len_q;
    logic [hydra_pkg::idx_w-1:0]  len_cur;

    assign word_in = rd_word;
    assign len_cur = (idx_q == '0) ? word_in.hdr.length : len_q;   // word 0 is the header.
    assign last    = busy && idx_q == len_cur;

    // ready only matters between packets.
    assign pop     = ~busy & ready & nonempty;
    assign rd_slot = slot_q;
    assign rd_idx  = idx_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            rd_vld <= 1'b0;
            rd_sop <= 1'b0;
            rd_eop <= 1'b0;
            free   <= 1'b0;
        end else begin
            rd_vld <= busy;
            rd_sop <= busy && idx_q == '0;
            rd_eop <= last;
            free   <= last;   // the slot is fully read once eop is out.
            if (pop) begin
                busy <= 1'b1;
            end else if (last) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            slot_q <= head_slot;
            idx_q  <= '0;
        end else if (busy) begin
            idx_q <= idx_q + 1'b1;
        end
        if (busy && idx_q == '0) len_q <= word_in.hdr.length;
        if (busy) rd_data <= rd_word;
        if (last) free_slot <= slot_q;
    end

endmodule

/* logic/hydra.sv */
`timescale 1ns/1ps

module hydra (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic [hydra_pkg::num_ports-1:0]                      wr_sop,
    input  logic [hydra_pkg::num_ports-1:0]                      wr_eop,
    input  logic [hydra_pkg::num_ports-1:0]                      wr_vld,
    input  logic [hydra_pkg::num_ports-1:0][hydra_pkg::word_w-1:0] wr_data,
    output logic [hydra_pkg::num_ports-1:0]                      pause,
    output logic                                                 full,
    input  logic [hydra_pkg::num_ports-1:0]                      ready,
    output logic [hydra_pkg::num_ports-1:0]                      rd_sop,
    output logic [hydra_pkg::num_ports-1:0]                      rd_eop,
    output logic [hydra_pkg::num_ports-1:0]                      rd_vld,
    output logic [hydra_pkg::num_ports-1:0][hydra_pkg::word_w-1:0] rd_data
);

    localparam int np = hydra_pkg::num_ports;

    // ============================================================
    // per-port links, indexed by port number.
    // ============================================================
    logic [np-1:0]                          rsv_req;
    logic [np-1:0]                          rsv_vld;
    logic [hydra_pkg::slot_w-1:0]           rsv_slot;   // shared, rsv_vld picks the taker.
    logic [np-1:0]                          buf_we;
    logic [np-1:0][hydra_pkg::slot_w-1:0]   buf_slot;
    logic [np-1:0][hydra_pkg::idx_w-1:0]    buf_idx;
    logic [np-1:0][hydra_pkg::word_w-1:0]   buf_data;
    logic [np-1:0]                          join_req;
    logic [np-1:0][hydra_pkg::port_w-1:0]   join_dest;
    logic [np-1:0][hydra_pkg::prior_w-1:0]  join_prior;
    logic [np-1:0][hydra_pkg::slot_w-1:0]   join_slot;
    logic [np-1:0]                          join_grant;
    logic [np-1:0]                          enq;
    logic [np-1:0][hydra_pkg::prior_w-1:0]  enq_prior;
    logic [np-1:0][hydra_pkg::slot_w-1:0]   enq_slot;
    logic [np-1:0]                          pop;
    logic [np-1:0]                          nonempty;
    logic [np-1:0][hydra_pkg::slot_w-1:0]   head_slot;
    logic [np-1:0][hydra_pkg::slot_w-1:0]   rd_slot;
    logic [np-1:0][hydra_pkg::idx_w-1:0]    rd_idx;
    logic [np-1:0][hydra_pkg::word_w-1:0]   rd_word;
    logic [np-1:0]                          free;
    logic [np-1:0][hydra_pkg::slot_w-1:0]   free_slot;

    slot_allocator slot_allocator_i (
        .clk(clk), .rst_n(rst_n),
        .rsv_req(rsv_req), .rsv_vld(rsv_vld), .rsv_slot(rsv_slot),
        .free(free), .free_slot(free_slot), .full(full)
    );

    packet_buffer packet_buffer_i (
        .clk(clk), .we(buf_we), .slot(buf_slot), .idx(buf_idx), .data(buf_data),
        .rd_slot(rd_slot), .rd_idx(rd_idx), .rd_data(rd_word)
    );

    join_arbiter join_arbiter_i (
        .join_req(join_req), .join_dest(join_dest), .join_prior(join_prior),
        .join_slot(join_slot), .join_grant(join_grant),
        .enq(enq), .enq_prior(enq_prior), .enq_slot(enq_slot)
    );

    for (genvar p = 0; p < np; p++) begin : g_port
        port_wr_frontend port_wr_frontend_i (
            .clk(clk), .rst_n(rst_n),
            .wr_sop(wr_sop[p]), .wr_eop(wr_eop[p]), .wr_vld(wr_vld[p]),
            .wr_data(wr_data[p]), .pause(pause[p]),
            .rsv_req(rsv_req[p]), .rsv_vld(rsv_vld[p]), .rsv_slot(rsv_slot),
            .buf_we(buf_we[p]), .buf_slot(buf_slot[p]), .buf_idx(buf_idx[p]),
            .buf_data(buf_data[p]),
            .join_req(join_req[p]), .join_dest(join_dest[p]), .join_prior(join_prior[p]),
            .join_slot(join_slot[p]), .join_grant(join_grant[p])
        );

        output_queue output_queue_i (
            .clk(clk), .rst_n(rst_n),
            .enq(enq[p]), .enq_prior(enq_prior[p]), .enq_slot(enq_slot[p]),
            .pop(pop[p]), .nonempty(nonempty[p]), .head_slot(head_slot[p])
        );

        port_rd_frontend port_rd_frontend_i (
            .clk(clk), .rst_n(rst_n),
            .ready(ready[p]), .nonempty(nonempty[p]), .head_slot(head_slot[p]),
            .pop(pop[p]), .rd_slot(rd_slot[p]), .rd_idx(rd_idx[p]), .rd_word(rd_word[p]),
            .rd_sop(rd_sop[p]), .rd_eop(rd_eop[p]), .rd_vld(rd_vld[p]),
            .rd_data(rd_data[p]), .free(free[p]), .free_slot(free_slot[p])
        );
    end

endmodule

/* verification/hydra_tb.sv */
`timescale 1ns/1ps

module hydra_tb;

    localparam int np          = hydra_pkg::num_ports;
    localparam int npri        = hydra_pkg::num_priors;
    localparam int max_words   = (np + 300 + np + hydra_pkg::num_slots) * hydra_pkg::slot_words;
    localparam int cycle_limit = 2 * max_words + 2000;   // every test at full packet length.

    logic                                 clk;
    logic                                 rst_n;
    logic [np-1:0]                        wr_sop;
    logic [np-1:0]                        wr_eop;
    logic [np-1:0]                        wr_vld;
    logic [np-1:0][hydra_pkg::word_w-1:0] wr_data;
    logic [np-1:0]                        pause;
    logic                                 full;
    logic [np-1:0]                        ready;
    logic [np-1:0]                        rd_sop;
    logic [np-1:0]                        rd_eop;
    logic [np-1:0]                        rd_vld;
    logic [np-1:0][hydra_pkg::word_w-1:0] rd_data;

    // one driver set per input, owned by that input's sender.
    logic                         sop_d  [np];
    logic                         eop_d  [np];
    logic                         vld_d  [np];
    logic [hydra_pkg::word_w-1:0] data_d [np];

    hydra_pkg::hdr_word_t exp_q [np*np*npri][$];   // (src, dest, prior) -> expected words.
    hydra_pkg::hdr_word_t out_log [np][$];          // headers in the order they left.
    hydra_pkg::hdr_word_t rx_hdr [np];
    hydra_pkg::hdr_word_t got;
    int rx_cnt [np];
    int key;
    int pending;        // packets sent and not yet fully seen at an output.
    int errors;
    int failed_tests;
    int traffic_left;
    int cycles;

    hydra hydra_i (
        .clk(clk), .rst_n(rst_n),
        .wr_sop(wr_sop), .wr_eop(wr_eop), .wr_vld(wr_vld), .wr_data(wr_data),
        .pause(pause), .full(full), .ready(ready),
        .rd_sop(rd_sop), .rd_eop(rd_eop), .rd_vld(rd_vld), .rd_data(rd_data)
    );

    for (genvar p = 0; p < np; p++) begin : g_drv
        assign wr_sop[p]  = sop_d[p];
        assign wr_eop[p]  = eop_d[p];
        assign wr_vld[p]  = vld_d[p];
        assign wr_data[p] = data_d[p];
    end

    always #20 clk = ~clk;

    task automatic check_word(input string name, input hydra_pkg::hdr_word_t got_w,
                              input hydra_pkg::hdr_word_t exp_w);
        if (got_w !== exp_w) begin
            $display("FAIL %s got %h expected %h", name, got_w, exp_w);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got_f, input logic exp_f);
        if (got_f !== exp_f) begin
            $display("FAIL %s got %h expected %h", name, got_f, exp_f);
            errors++;
        end
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #1;   // inputs move just after the edge.
    endtask

    // ============================================================
    // packet source and traffic.
    // ============================================================
    task automatic send_pkt(input int src, input int dest, input int prior, input int len,
                            output hydra_pkg::hdr_word_t hdr);
        hydra_pkg::hdr_word_t w;
        int q;
        w.data          = hydra_pkg::word_w'($urandom);
        w.hdr.length    = hydra_pkg::idx_w'(len);
        w.hdr.prior     = hydra_pkg::prior_w'(prior);
        w.hdr.dest      = hydra_pkg::port_w'(dest);
        w.hdr.rsvd[1:0] = 2'(src);   // source tag for the model lookup.
        hdr = w;
        q   = (src * np + dest) * npri + prior;
        while (pause[src]) next_cycle();
        pending++;
        for (int k = 0; k <= len; k++) begin
            exp_q[q].push_back(w);
            sop_d[src]  = (k == 0);
            eop_d[src]  = (k == len);
            vld_d[src]  = 1'b1;
            data_d[src] = w.data;
            next_cycle();
            w.data = hydra_pkg::word_w'($urandom);
        end
        sop_d[src] = 1'b0;
        eop_d[src] = 1'b0;
        vld_d[src] = 1'b0;
    endtask

    task automatic run_traffic(input int src, input int count);
        hydra_pkg::hdr_word_t h;
        for (int n = 0; n < count; n++) begin
            repeat ($urandom_range(0, 3)) next_cycle();   // idle gap.
            send_pkt(src, $urandom_range(0, np - 1), $urandom_range(0, npri - 1),
                     $urandom_range(0, hydra_pkg::slot_words - 1), h);
        end
        traffic_left--;
    endtask

    task automatic wait_drain;
        while (pending != 0) next_cycle();
    endtask

    task automatic report_test(input string name, input int base);
        if (errors == base) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, errors - base);
        end
    endtask

    // ============================================================
    // output monitor, sampled at the falling edge.
    // ============================================================
    always @(negedge clk) begin
        if (rst_n) begin
            for (int o = 0; o < np; o++) begin
                if (rd_vld[o]) begin
                    got = rd_data[o];
                    if (rx_cnt[o] == 0) begin
                        rx_hdr[o] = got;
                        out_log[o].push_back(got);
                    end
                    key = (int'(rx_hdr[o].hdr.rsvd[1:0]) * np + o) * npri
                          + int'(rx_hdr[o].hdr.prior);
                    check_flag($sformatf("rd_sop[%0d]", o), rd_sop[o], rx_cnt[o] == 0);
                    check_flag($sformatf("rd_eop[%0d]", o), rd_eop[o],
                               rx_cnt[o] == int'(rx_hdr[o].hdr.length));
                    if (exp_q[key].size() == 0) begin
                        $display("output %0d sent a word that no input has pending", o);
                        errors++;
                    end else begin
                        check_word($sformatf("rd_data[%0d]", o), got, exp_q[key].pop_front());
                    end
                    if (rx_cnt[o] == int'(rx_hdr[o].hdr.length)) begin
                        rx_cnt[o] = 0;
                        pending--;
                    end else begin
                        rx_cnt[o]++;
                    end
                end else if (rx_cnt[o] != 0) begin
                    check_flag($sformatf("rd_vld[%0d]", o), rd_vld[o], 1'b1);   // no gaps.
                end
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        hydra_pkg::hdr_word_t sent [npri];
        hydra_pkg::hdr_word_t h;
        int order [npri];
        int base;
        int j;
        int t;
        clk          = 1'b0;
        rst_n        = 1'b0;
        ready        = '0;
        pending      = 0;
        errors       = 0;
        failed_tests = 0;
        traffic_left = 0;
        for (int p = 0; p < np; p++) begin
            sop_d[p]  = 1'b0;
            eop_d[p]  = 1'b0;
            vld_d[p]  = 1'b0;
            data_d[p] = '0;
            rx_cnt[p] = 0;
        end
        void'($urandom(17785));
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        base = errors;   // reset state.
        check_flag("full", full, 1'b0);
        for (int p = 0; p < np; p++) begin
            check_flag($sformatf("rd_vld[%0d]", p), rd_vld[p], 1'b0);
            check_flag($sformatf("rd_sop[%0d]", p), rd_sop[p], 1'b0);
            check_flag($sformatf("rd_eop[%0d]", p), rd_eop[p], 1'b0);
        end
        repeat (np + 2) next_cycle();
        for (int p = 0; p < np; p++) check_flag($sformatf("pause[%0d]", p), pause[p], 1'b0);
        report_test("reset state", base);

        base  = errors;   // one packet to each output.
        ready = '1;
        for (int d = 0; d < np; d++) begin
            send_pkt(0, d, $urandom_range(0, npri - 1), $urandom_range(0, 15), h);
        end
        wait_drain();
        report_test("single packet", base);

        base         = errors;   // 300 packets with a random ready.
        traffic_left = np;
        fork
            run_traffic(0, 75);
            run_traffic(1, 75);
            run_traffic(2, 75);
            run_traffic(3, 75);
            while (traffic_left != 0 || pending != 0) begin
                ready = np'($urandom);
                next_cycle();
            end
        join
        ready = '1;
        report_test("random traffic", base);

        base     = errors;   // strict priority on output 2.
        ready[2] = 1'b0;
        for (int k = 0; k < npri; k++) order[k] = k;
        for (int k = npri - 1; k > 0; k--) begin
            j        = $urandom_range(0, k);
            t        = order[k];
            order[k] = order[j];
            order[j] = t;
        end
        if (order[0] == npri - 1) begin
            t               = order[0];   // the top priority must not go first.
            order[0]        = order[npri - 1];
            order[npri - 1] = t;
        end
        out_log[2].delete();
        for (int k = 0; k < npri; k++) begin
            send_pkt(1, 2, order[k], $urandom_range(0, 15), sent[order[k]]);
        end
        while (pause[1]) next_cycle();   // last packet has joined its queue.
        ready[2] = 1'b1;
        wait_drain();
        if (out_log[2].size() != npri) begin
            $display("output 2 delivered %0d packets, not %0d", out_log[2].size(), npri);
            errors++;
        end else begin
            for (int k = 0; k < npri; k++) begin
                check_word("rd_data[2] header", out_log[2][k], sent[npri - 1 - k]);
            end
        end
        report_test("strict priority", base);

        base  = errors;   // fill every slot, then drain.
        ready = '0;
        for (int r = 0; r < hydra_pkg::num_slots / np; r++) begin
            while (pause != '0) next_cycle();   // each input holds a slot for this round.
            traffic_left = np;
            fork
                run_traffic(0, 1);
                run_traffic(1, 1);
                run_traffic(2, 1);
                run_traffic(3, 1);
            join
        end
        while (!full) next_cycle();
        for (int p = 0; p < np; p++) check_flag($sformatf("pause[%0d]", p), pause[p], 1'b1);
        ready = '1;
        wait_drain();
        next_cycle();
        check_flag("full", full, 1'b0);
        report_test("full and recovery", base);

        $display("tests run: 5, tests failed: %0d, errors: %0d", failed_tests, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
logic/hydra_pkg.sv
logic/port_wr_frontend.sv
logic/slot_allocator.sv
logic/packet_buffer.sv
logic/join_arbiter.sv
logic/output_queue.sv
logic/port_rd_frontend.sv
logic/hydra.sv
verification/hydra_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the hydra testbench with verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module hydra_tb \
    -f list.f -o hydra_sim || exit 1

out="$(./obj_dir/hydra_sim)"
echo "$out"
echo "$out" | grep -q "TEST PASSED" && exit 0 || exit 1
